// File: rtl/blk_wr_if.sv
// Write control between the padding FSM and the block buffer
// block_full and last_word are combinational from the word counter

`timescale 1ns/1ps
`default_nettype none

interface blk_wr_if
  import sha3pad_pkg::*;
();

  // Controller side
  logic     wr_en;
  mux_sel_e sel;
  logic     clr;

  // Buffer side status
  logic     block_full;
  logic     last_word;

  modport ctrl_mp (
    output wr_en,
    output sel,
    output clr,
    input  block_full,
    input  last_word
  );

  modport buf_mp (
    input  wr_en,
    input  sel,
    input  clr,
    output block_full,
    output last_word
  );

endinterface

`default_nettype wire

// File: rtl/pad_block_buf.sv
// Block buffer with word counter and write-data mux
// strength_i and mode_i must stay stable from start to absorbed
// The buffer is cleared by clr, so words above the rate read as zero

`timescale 1ns/1ps
`default_nettype none

module pad_block_buf
  import sha3pad_pkg::*;
(
  input  wire                    clk_i,
  input  wire                    rst_b,

  input  keccak_strength_e       strength_i,
  input  sha3_mode_e             mode_i,

  input  wire [MsgWidth-1:0]     msg_data_i,
  input  wire [MsgWidth-9:0]     tail_data_i,
  input  wire [MsgStrbW-2:0]     tail_strb_i,

  output logic [StateW-1:0]      keccak_data_o,

  blk_wr_if.buf_mp               wr
);

  logic [MsgCountW-1:0]                 rate;
  logic [MsgCountW-1:0]                 cnt_q;
  logic [4:0]                           funcpad;
  logic [MsgWidth-9:0]                  tail_bytes;
  logic [2:0]                           pad_pos;
  logic [MsgWidth-1:0]                  end_word;
  logic [MsgWidth-1:0]                  wr_data;
  logic [MsgEntries-1:0][MsgWidth-1:0]  buf_q;

  ////////////////////////////////////////
  // Rate and word counter
  ////////////////////////////////////////

  always_comb begin
    unique case (strength_i)
      L128:    rate = KeccakRateWords[0];
      L224:    rate = KeccakRateWords[1];
      L256:    rate = KeccakRateWords[2];
      L384:    rate = KeccakRateWords[3];
      default: rate = KeccakRateWords[4];
    endcase
  end

  // Counter is also the write address
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
    end else if (wr.clr) begin
      cnt_q <= '0;
    end else if (wr.wr_en) begin
      cnt_q <= cnt_q + 5'd1;
    end
  end

  assign wr.block_full = (cnt_q == rate);
  assign wr.last_word  = ((cnt_q + 5'd1) == rate);

  ////////////////////////////////////////
  // Write data
  ////////////////////////////////////////

  assign funcpad = (mode_i == Shake) ? FuncPadShake : FuncPadSha3;

  // Keep strobed tail bytes and find the first free byte for the suffix
  always_comb begin
    tail_bytes = '0;
    pad_pos    = '0;
    for (int i = 0; i < MsgStrbW - 1; i++) begin
      if (tail_strb_i[i]) begin
        tail_bytes[8*i +: 8] = tail_data_i[8*i +: 8];
        pad_pos              = pad_pos + 3'd1;
      end
    end
  end

  // pad10*1 end bit only in the last rate word
  assign end_word = {wr.last_word, {(MsgWidth-1){1'b0}}};

  always_comb begin
    unique case (wr.sel)
      MuxFifo:    wr_data = msg_data_i;
      MuxFuncPad: wr_data = end_word | {8'h00, tail_bytes} |
                            (MsgWidth'(funcpad) << {pad_pos, 3'b000});
      MuxZeroEnd: wr_data = end_word;
      default:    wr_data = '0;
    endcase
  end

  ////////////////////////////////////////
  // Block buffer
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr.clr) begin
      buf_q <= '0;
    end else if (wr.wr_en) begin
      buf_q[cnt_q] <= wr_data;
    end
  end

  assign keccak_data_o = buf_q;

  // Controller never writes past the rate
  wr_addr_in_rate_a: assert property (
    @(posedge clk_i) disable iff (!rst_b)
    wr.wr_en |-> (cnt_q < rate)
  );

endmodule

`default_nettype wire

// File: rtl/pad_ctrl.sv
// Padding FSM for SHA3 and SHAKE
// Assumes start_i and process_i are single-cycle pulses, never together
// Assumes each Keccak run completes before the next run is requested

`timescale 1ns/1ps
`default_nettype none

module pad_ctrl
  import sha3pad_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_b,

  input  wire        start_i,
  input  wire        process_i,

  // Keccak control
  input  wire        keccak_ready_i,
  input  wire        keccak_complete_i,
  output logic       keccak_run_o,
  output logic       absorbed_o,

  // Message side
  input  wire        word_valid_i,
  output logic       accept_o,
  output logic       hold_o,
  output logic       tail_clr_o,

  // Block buffer control
  blk_wr_if.ctrl_mp  wr
);

  pad_st_e st_q;
  pad_st_e st_d;
  logic    process_q;
  logic    absorbed_d;

  ////////////////////////////////////////
  // Process latch
  ////////////////////////////////////////

  // process_i may come while a full block still waits for Keccak
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end else if (start_i) begin
      process_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // State and absorbed registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q       <= StIdle;
      absorbed_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  // Message phase is a plain level for the input side
  assign accept_o = (st_q == StMessage);

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////

  always_comb begin
    st_d         = st_q;
    keccak_run_o = 1'b0;
    absorbed_d   = 1'b0;
    hold_o       = 1'b0;
    tail_clr_o   = 1'b0;
    wr.wr_en     = 1'b0;
    wr.sel       = MuxNone;
    wr.clr       = 1'b0;

    unique case (st_q)
      StIdle: begin
        // Keep the buffer empty between messages
        wr.clr = 1'b1;
        if (start_i) begin
          st_d = StMessage;
        end
      end

      StMessage: begin
        wr.sel = MuxFifo;
        if (wr.block_full) begin
          // A full block always goes out before padding starts
          hold_o = 1'b1;
          if (keccak_ready_i) begin
            keccak_run_o = 1'b1;
            wr.clr       = 1'b1;
          end
        end else if (process_q || process_i) begin
          hold_o = 1'b1;
          st_d   = StPad;
        end else begin
          wr.wr_en = word_valid_i;
        end
      end

      // Suffix word, merged with any tail bytes
      StPad: begin
        wr.sel   = MuxFuncPad;
        wr.wr_en = 1'b1;
        if (wr.last_word) begin
          st_d = StPadRun;
        end else begin
          st_d = StPad01;
        end
      end

      // Suffix filled the block, run once Keccak can take it
      StPadRun: begin
        if (keccak_ready_i) begin
          keccak_run_o = 1'b1;
          wr.clr       = 1'b1;
          st_d         = StPadFlush;
        end
      end

      // Zero fill up to the end bit in the last rate word
      StPad01: begin
        wr.sel = MuxZeroEnd;
        if (wr.block_full) begin
          if (keccak_ready_i) begin
            keccak_run_o = 1'b1;
            wr.clr       = 1'b1;
            st_d         = StPadFlush;
          end
        end else begin
          wr.wr_en = 1'b1;
        end
      end

      StPadFlush: begin
        wr.clr     = 1'b1;
        tail_clr_o = 1'b1;
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          st_d       = StIdle;
        end
      end

      default: begin
        st_d = StIdle;
      end
    endcase
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  run_pulse_a: assert property (
    @(posedge clk_i) disable iff (!rst_b)
    keccak_run_o |=> !keccak_run_o
  );

  // Zero fill is only entered when the suffix did not take the last word
  pad01_not_last_a: assert property (
    @(posedge clk_i) disable iff (!rst_b)
    (st_q == StPad01) && $past(st_q == StPad) |-> !wr.block_full
  );

endmodule

`default_nettype wire

// File: rtl/pad_msg_in.sv
// Message input side of the padding stage
// A partial word must be the last word of a message, strobes contiguous from byte 0
// Ready is combinational and only high while the controller accepts messages

`timescale 1ns/1ps
`default_nettype none

module pad_msg_in
  import sha3pad_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_b,

  // Message stream
  input  wire                     msg_valid_i,
  input  wire [MsgStrbW-1:0]      msg_strb_i,
  // Only the low seven bytes can ever be part of a tail
  input  wire [MsgWidth-9:0]      msg_data_i,
  output logic                    msg_ready_o,

  // Controller handshake
  input  wire                     accept_i,
  input  wire                     hold_i,
  input  wire                     tail_clr_i,
  output logic                    word_valid_o,

  // Latched partial word for the suffix merge
  output logic [MsgWidth-9:0]     tail_data_o,
  output logic [MsgStrbW-2:0]     tail_strb_o
);

  logic                msg_full;
  logic                tail_load;
  logic [MsgWidth-9:0] tail_data_q;
  logic [MsgStrbW-2:0] tail_strb_q;

  ////////////////////////////////////////
  // Beat classification
  ////////////////////////////////////////

  // All strobes set means a word for the block buffer
  assign msg_full = &msg_strb_i;

  // Partial beats are taken even while the buffer is held,
  // they never touch the buffer directly
  assign tail_load = accept_i & msg_valid_i & ~msg_full;

  // Full word goes to the buffer unless the block is waiting for Keccak
  assign word_valid_o = accept_i & msg_valid_i & msg_full & ~hold_i;

  assign msg_ready_o = tail_load | word_valid_o;

  ////////////////////////////////////////
  // Tail registers
  ////////////////////////////////////////

  // Strobe state decides where the suffix lands
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      tail_strb_q <= '0;
    end else if (tail_clr_i) begin
      tail_strb_q <= '0;
    end else if (tail_load) begin
      tail_strb_q <= msg_strb_i[MsgStrbW-2:0];
    end
  end

  // Tail bytes, qualified by the strobe
  always_ff @(posedge clk_i) begin
    if (tail_load) begin
      tail_data_q <= msg_data_i;
    end
  end

  assign tail_data_o = tail_data_q;
  assign tail_strb_o = tail_strb_q;

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // Captured tail strobes run from byte 0 without gaps so the suffix lands right after them
  tail_contiguous_a: assert property (
    @(posedge clk_i) disable iff (!rst_b)
    tail_load |-> msg_strb_i[0] && ((msg_strb_i & (msg_strb_i + 1'b1)) == '0)
  );

endmodule

`default_nettype wire

// File: rtl/sha3pad_pkg.sv
// Shared widths, rates and encodings for the SHA3/SHAKE padding stage
// Message words are fixed at 64 bits with one strobe bit per byte
// Only SHA3 and SHAKE suffixes are supported

`default_nettype none

package sha3pad_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int MsgWidth   = 64;
  localparam int MsgStrbW   = MsgWidth / 8;
  localparam int StateW     = 1600;
  localparam int MsgEntries = StateW / MsgWidth;
  localparam int MsgAddrW   = 5;
  localparam int MsgCountW  = 5;

  ////////////////////////////////////////
  // Modes and strengths
  ////////////////////////////////////////

  typedef enum logic [0:0] {
    Sha3,
    Shake
  } sha3_mode_e;

  typedef enum logic [2:0] {
    L128,
    L224,
    L256,
    L384,
    L512
  } keccak_strength_e;

  // Rate in 64-bit words, indexed by strength
  localparam logic [MsgCountW-1:0] KeccakRateWords [5] = '{
    5'd21, 5'd18, 5'd17, 5'd13, 5'd9
  };

  // Function suffix with the first pad10*1 bit already appended
  localparam logic [4:0] FuncPadSha3  = 5'b00110;
  localparam logic [4:0] FuncPadShake = 5'b11111;

  ////////////////////////////////////////
  // Control encodings
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    StIdle,
    StMessage,
    StPad,
    StPadRun,
    StPad01,
    StPadFlush
  } pad_st_e;

  // Source of the word written into the block buffer
  typedef enum logic [1:0] {
    MuxNone,
    MuxFifo,
    MuxFuncPad,
    MuxZeroEnd
  } mux_sel_e;

endpackage

`default_nettype wire

// File: rtl/sha3pad_top.sv
// SHA3/SHAKE message padding in front of a Keccak permutation
// keccak_data_o is valid in the cycle keccak_run_o is high
// mode_i and strength_i must be held from start_i until absorbed_o

`timescale 1ns/1ps
`default_nettype none

module sha3pad_top
  import sha3pad_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   rst_b,

  // Message stream
  input  wire                   msg_valid_i,
  input  wire [MsgWidth-1:0]    msg_data_i,
  input  wire [MsgStrbW-1:0]    msg_strb_i,
  output logic                  msg_ready_o,

  // Configuration
  input  sha3_mode_e            mode_i,
  input  keccak_strength_e      strength_i,

  // Control pulses
  input  wire                   start_i,
  input  wire                   process_i,

  // Keccak side
  output logic [StateW-1:0]     keccak_data_o,
  input  wire                   keccak_ready_i,
  output logic                  keccak_run_o,
  input  wire                   keccak_complete_i,
  output logic                  absorbed_o
);

  logic                accept;
  logic                hold;
  logic                tail_clr;
  logic                word_valid;
  logic [MsgWidth-9:0] tail_data;
  logic [MsgStrbW-2:0] tail_strb;

  blk_wr_if i_blk_wr ();

  pad_msg_in i_pad_msg_in (
    .clk_i        (clk_i),
    .rst_b        (rst_b),
    .msg_valid_i  (msg_valid_i),
    .msg_strb_i   (msg_strb_i),
    .msg_data_i   (msg_data_i[MsgWidth-9:0]),
    .msg_ready_o  (msg_ready_o),
    .accept_i     (accept),
    .hold_i       (hold),
    .tail_clr_i   (tail_clr),
    .word_valid_o (word_valid),
    .tail_data_o  (tail_data),
    .tail_strb_o  (tail_strb)
  );

  pad_ctrl i_pad_ctrl (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .start_i           (start_i),
    .process_i         (process_i),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_complete_i (keccak_complete_i),
    .keccak_run_o      (keccak_run_o),
    .absorbed_o        (absorbed_o),
    .word_valid_i      (word_valid),
    .accept_o          (accept),
    .hold_o            (hold),
    .tail_clr_o        (tail_clr),
    .wr                (i_blk_wr.ctrl_mp)
  );

  pad_block_buf i_pad_block_buf (
    .clk_i         (clk_i),
    .rst_b         (rst_b),
    .strength_i    (strength_i),
    .mode_i        (mode_i),
    .msg_data_i    (msg_data_i),
    .tail_data_i   (tail_data),
    .tail_strb_i   (tail_strb),
    .keccak_data_o (keccak_data_o),
    .wr            (i_blk_wr.buf_mp)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the padding testbench with Verilator
# The exit status is non-zero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module tb_sha3pad -f sim.f \
    --Mdir obj_dir -o tb_sha3pad; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_sha3pad; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: sim.f
rtl/sha3pad_pkg.sv
rtl/blk_wr_if.sv
rtl/pad_msg_in.sv
rtl/pad_ctrl.sv
rtl/pad_block_buf.sv
rtl/sha3pad_top.sv
tests/tb_sha3pad.sv

// File: tests/tb_sha3pad.sv
// Testbench for the SHA3/SHAKE padding stage
// Keccak is a responder with a random busy time of 3 to 20 cycles
// keccak_ready_i stays low while a permutation is in flight
// Any failure stops the run at once

`timescale 1ns/1ps
`default_nettype none

module tb_sha3pad
  import sha3pad_pkg::*;
();

  localparam int TimeoutCycles = 4000;

  typedef logic [7:0]        byte_q_t  [$];
  typedef logic [StateW-1:0] block_q_t [$];

  logic                clk_i;
  logic                rst_b;
  logic                msg_valid_i;
  logic [MsgWidth-1:0] msg_data_i;
  logic [MsgStrbW-1:0] msg_strb_i;
  logic                msg_ready_o;
  sha3_mode_e          mode_i;
  keccak_strength_e    strength_i;
  logic                start_i;
  logic                process_i;
  logic [StateW-1:0]   keccak_data_o;
  logic                keccak_ready_i;
  logic                keccak_run_o;
  logic                keccak_complete_i;
  logic                absorbed_o;

  // Captured blocks, blocks still expected, and the most recent capture
  logic [StateW-1:0]   got_q [$];
  logic [StateW-1:0]   exp_q [$];
  logic [StateW-1:0]   last_blk;
  int                  run_count;

  sha3pad_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Checks and reference model
  ////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [StateW-1:0] got,
                             input logic [StateW-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Rate is the state size minus twice the security strength
  function automatic int rate_bytes(input keccak_strength_e strength);
    int bits;
    case (strength)
      L128:    bits = 128;
      L224:    bits = 224;
      L256:    bits = 256;
      L384:    bits = 384;
      default: bits = 512;
    endcase
    return 200 - 2 * (bits / 8);
  endfunction

  // Suffix byte, zero fill, end bit, then split into rate-sized blocks
  function automatic void ref_blocks(input byte_q_t msg, input sha3_mode_e mode,
                                     input keccak_strength_e strength,
                                     output block_q_t blocks);
    byte_q_t           padded;
    logic [StateW-1:0] blk;
    int                rb;
    rb     = rate_bytes(strength);
    padded = msg;
    blocks = {};
    padded.push_back((mode == Shake) ? 8'h1f : 8'h06);
    while (padded.size() % rb != 0) begin
      padded.push_back(8'h00);
    end
    padded[padded.size() - 1] = padded[padded.size() - 1] | 8'h80;
    for (int b = 0; b < padded.size() / rb; b++) begin
      // Bytes above the rate stay zero
      blk = '0;
      for (int i = 0; i < rb; i++) begin
        blk[8*i +: 8] = padded[b*rb + i];
      end
      blocks.push_back(blk);
    end
  endfunction

  function automatic void make_msg(output byte_q_t msg, input int len);
    msg = {};
    for (int i = 0; i < len; i++) begin
      msg.push_back(8'($urandom));
    end
  endfunction

  ////////////////////////////////////////
  // Keccak responder and block compare
  ////////////////////////////////////////

  initial begin : keccak_model
    int unsigned delay;
    keccak_ready_i    = 1'b0;
    keccak_complete_i = 1'b0;
    run_count         = 0;
    forever begin
      @(posedge clk_i);
      if (keccak_run_o) begin
        got_q.push_back(keccak_data_o);
        last_blk  = keccak_data_o;
        run_count = run_count + 1;
        delay     = $urandom_range(20, 3);
        @(negedge clk_i);
        // Busy until complete
        keccak_ready_i = 1'b0;
        repeat (delay - 1) @(negedge clk_i);
        keccak_complete_i = 1'b1;
        @(negedge clk_i);
        keccak_complete_i = 1'b0;
      end else begin
        @(negedge clk_i);
      end
      // Mostly ready, random stalls
      keccak_ready_i = rst_b && ($urandom_range(3, 0) != 0);
    end
  end

  initial begin : compare_blocks
    logic [StateW-1:0] got;
    logic [StateW-1:0] exp;
    forever begin
      @(negedge clk_i);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        if (exp_q.size() == 0) begin
          stop_on_error("A Keccak run was seen with no block left to expect");
        end else begin
          exp = exp_q.pop_front();
          check_value("keccak_data_o", got, exp);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Holds one beat until msg_ready_o, returns on a falling edge
  task automatic push_word(input logic [MsgWidth-1:0] data, input logic [MsgStrbW-1:0] strb);
    int cycles;
    cycles      = 0;
    msg_valid_i = 1'b1;
    msg_data_i  = data;
    msg_strb_i  = strb;
    do begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > TimeoutCycles) begin
        stop_on_error("Timeout: msg_ready_o never rose for a message word");
      end
    end while (!msg_ready_o);
    @(negedge clk_i);
    msg_valid_i = 1'b0;
  endtask

  task automatic wait_absorbed();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles = cycles + 1;
      if (cycles > TimeoutCycles) begin
        stop_on_error("Timeout: absorbed_o never pulsed after process_i");
      end
    end while (!absorbed_o);
    // One-cycle pulse
    @(posedge clk_i);
    check_value("absorbed_o", StateW'(absorbed_o), '0);
    @(negedge clk_i);
  endtask

  task automatic send_message(input byte_q_t msg, input sha3_mode_e mode,
                              input keccak_strength_e strength);
    block_q_t            blocks;
    logic [MsgWidth-1:0] data;
    logic [MsgStrbW-1:0] strb;
    int                  runs_before;
    int                  nwords;
    ref_blocks(msg, mode, strength, blocks);
    foreach (blocks[i]) begin
      exp_q.push_back(blocks[i]);
    end
    runs_before = run_count;
    nwords      = (msg.size() + 7) / 8;
    mode_i      = mode;
    strength_i  = strength;
    start_i     = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    for (int w = 0; w < nwords; w++) begin
      // Random filler above the strobes of a partial word
      data = {$urandom, $urandom};
      strb = '0;
      for (int b = 0; b < MsgStrbW; b++) begin
        if (8*w + b < msg.size()) begin
          data[8*b +: 8] = msg[8*w + b];
          strb[b]        = 1'b1;
        end
      end
      push_word(data, strb);
      if ($urandom_range(3, 0) == 0) begin
        @(negedge clk_i);
      end
    end
    process_i = 1'b1;
    @(negedge clk_i);
    process_i = 1'b0;
    wait_absorbed();
    check_value("keccak_run_o pulses", StateW'(run_count - runs_before), StateW'(blocks.size()));
    check_value("blocks not seen", StateW'(exp_q.size()), '0);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    byte_q_t           msg;
    keccak_strength_e  strengths [5];
    logic [StateW-1:0] exp_blk;
    int                rb;
    strengths = '{L128, L224, L256, L384, L512};
    void'($urandom(32'h85fc));
    rst_b       = 1'b0;
    msg_valid_i = 1'b0;
    msg_data_i  = '0;
    msg_strb_i  = '0;
    mode_i      = Sha3;
    strength_i  = L256;
    start_i     = 1'b0;
    process_i   = 1'b0;
    repeat (16) @(negedge clk_i);
    rst_b = 1'b1;

    // Quiet outputs before start, even with a word offered
    msg_valid_i = 1'b1;
    msg_strb_i  = '1;
    msg_data_i  = {$urandom, $urandom};
    repeat (4) begin
      @(posedge clk_i);
      check_value("msg_ready_o", StateW'(msg_ready_o), '0);
      check_value("keccak_run_o", StateW'(keccak_run_o), '0);
      check_value("absorbed_o", StateW'(absorbed_o), '0);
    end
    @(negedge clk_i);
    msg_valid_i = 1'b0;

    // Short SHA3-256 message of whole words
    make_msg(msg, 24);
    send_message(msg, Sha3, L256);

    // SHAKE128 with every partial final word length
    for (int r = 1; r < MsgStrbW; r++) begin
      make_msg(msg, 16 + r);
      send_message(msg, Shake, L128);
      check_value("suffix byte", StateW'(last_blk[8*(16+r) +: 8]), StateW'(8'h1f));
    end

    // Suffix in the last rate byte
    rb = rate_bytes(L256);
    make_msg(msg, rb - 1);
    send_message(msg, Sha3, L256);
    check_value("last rate byte", StateW'(last_blk[8*(rb-1) +: 8]), StateW'(8'h86));
    rb = rate_bytes(L128);
    make_msg(msg, rb - 1);
    send_message(msg, Shake, L128);
    check_value("last rate byte", StateW'(last_blk[8*(rb-1) +: 8]), StateW'(8'h9f));

    // Exactly one rate, second block is padding only
    rb = rate_bytes(L512);
    make_msg(msg, rb);
    send_message(msg, Sha3, L512);
    exp_blk               = '0;
    exp_blk[7:0]          = 8'h06;
    exp_blk[8*(rb-1) +: 8] = 8'h80;
    check_value("padding block", last_blk, exp_blk);

    // Multi-block messages over all strengths
    foreach (strengths[s]) begin
      rb = rate_bytes(strengths[s]);
      make_msg(msg, 2 * rb + int'($urandom_range(rb - 1, 0)));
      send_message(msg, ($urandom_range(1, 0) == 0) ? Sha3 : Shake, strengths[s]);
    end

    // Long all-ones message with a tail, then a short whole-word one with the same rate
    rb  = rate_bytes(L224);
    msg = {};
    repeat (2 * rb - 3) msg.push_back(8'hff);
    send_message(msg, Sha3, L224);
    make_msg(msg, 8);
    send_message(msg, Sha3, L224);

    if (exp_q.size() != 0) begin
      stop_on_error($sformatf("%0d expected blocks were never sent", exp_q.size()));
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire
